// ==== tests/layer_golden.txt ====
# menu bl_x bl_y wh_x wh_y fh_x0..fh_x6 fh_y0..fh_y6
# then cycles screen_sum sprite_sum ball_start, all decimal, one frame per line

# normal frame, holes spread along a diagonal
0 100 50 200 60 10 50 90 130 170 210 250 20 30 40 50 60 70 80 66816 1856677248 51821952 16100

# sprites on the screen edges and corners
0 288 148 0 0 0 288 32 64 5 250 123 148 0 100 64 7 120 45 66816 1912874368 51821952 47648

# start menu, holes and win hole skipped
1 150 75 40 40 10 50 90 130 170 210 250 20 30 40 50 60 70 80 58624 1688675712 29805952 24150

# normal frame right after a start menu
0 17 133 281 99 1 2 3 100 200 280 140 1 2 3 100 140 10 90 66816 1895153024 51821952 42577

# first frame again
0 100 50 200 60 10 50 90 130 170 210 250 20 30 40 50 60 70 80 66816 1856677248 51821952 16100

// ==== flist.f ====
src/layer_pkg.sv
src/sprite_walker.sv
src/failhole_sequencer.sv
src/layer_sequencer.sv
src/layer_control.sv
tests/tb_clock_gen.sv
tests/tb_layer_control.sv

// ==== run.sh ====
#!/bin/sh
# build and run the layer_control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_layer_control

verilator --binary --timing -f flist.f --top-module tb_layer_control \
    --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation returned an error, see $LOG"
    exit 1
fi

if grep -q "Everything OK" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL, see $LOG"
exit 1

// ==== tests/tb_layer_control.sv ====
`timescale 1ns/1ps

module tb_layer_control
    import layer_pkg::*;
();

    localparam int RESET_LIMIT  = 40;
    localparam int RISE_LIMIT   = 8;
    localparam int FRAME_LIMIT  = 70000;
    localparam int INJECT_CYCLE = 30000;
    localparam int MAX_GAP      = 50;
    localparam int GOLD_FIELDS  = 23;

    logic         CLK;
    logic         rst;
    logic         pix_stb;
    logic         screen_end;
    logic         start_menu;
    coord_t       bl_x;
    coord_t       bl_y;
    coord_t       wh_x;
    coord_t       wh_y;
    fh_pos_bus_t  fh_pos_x;
    fh_pos_bus_t  fh_pos_y;
    vram_addr_t   screen_addr;
    sprite_addr_t sprite_addr;
    logic         drawing;

    // one frame from the golden file
    int           gold_menu;
    int           gold_bl_x;
    int           gold_bl_y;
    int           gold_wh_x;
    int           gold_wh_y;
    int           gold_fh_x [FAILHOLE_COUNT];
    int           gold_fh_y [FAILHOLE_COUNT];
    int           gold_count;
    logic [31:0]  gold_screen_sum;
    logic [31:0]  gold_sprite_sum;
    int           gold_ball_addr;

    tb_clock_gen #(
        .PERIOD_NS   (20),
        .RESET_CYCLES(16)
    ) u_clock_gen (
        .CLK(CLK),
        .rst(rst)
    );

    layer_control i_layer_control (
        .CLK          (CLK),
        .rst          (rst),
        .i_pix_stb    (pix_stb),
        .i_screen_end (screen_end),
        .i_start_menu (start_menu),
        .i_bl_x       (bl_x),
        .i_bl_y       (bl_y),
        .i_wh_x       (wh_x),
        .i_wh_y       (wh_y),
        .i_fh_pos_x   (fh_pos_x),
        .i_fh_pos_y   (fh_pos_y),
        .o_screen_addr(screen_addr),
        .o_sprite_addr(sprite_addr),
        .o_drawing    (drawing)
    );

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic wait_drive_point();
        @(posedge CLK);
        #2;
    endtask

    task automatic wait_sample_point();
        @(negedge CLK);
    endtask

    task automatic check_idle_outputs(input string when);
        expect_equal({when, ": drawing"}, 32'(drawing), 32'd0);
        expect_equal({when, ": screen address"}, 32'(screen_addr), 32'd0);
        expect_equal({when, ": sprite address"}, 32'(sprite_addr), 32'd0);
    endtask

    task automatic load_positions();
        start_menu = (gold_menu != 0);
        bl_x       = coord_t'(gold_bl_x);
        bl_y       = coord_t'(gold_bl_y);
        wh_x       = coord_t'(gold_wh_x);
        wh_y       = coord_t'(gold_wh_y);
        for (int k = 0; k < FAILHOLE_COUNT; k++) begin
            fh_pos_x[k*COORD_BITS +: COORD_BITS] = coord_t'(gold_fh_x[k]);
            fh_pos_y[k*COORD_BITS +: COORD_BITS] = coord_t'(gold_fh_y[k]);
        end
    endtask

    task automatic run_frame(input int frame);
        int          gap;
        int          waited;
        int          count;
        logic [31:0] screen_sum;
        logic [31:0] sprite_sum;

        gap = 1 + int'($urandom % MAX_GAP);
        for (int c = 0; c < gap; c++) begin
            wait_drive_point();
            if (c == 0) begin
                load_positions();
            end
            // either one alone starts nothing
            pix_stb    = 1'($urandom);
            screen_end = ~pix_stb;
            wait_sample_point();
            check_idle_outputs($sformatf("frame %0d idle gap", frame));
        end

        wait_drive_point();
        pix_stb    = 1'b1;
        screen_end = 1'b1;
        wait_sample_point();
        check_idle_outputs($sformatf("frame %0d frame end", frame));
        wait_drive_point();
        pix_stb    = 1'b0;
        screen_end = 1'b0;
        wait_sample_point();

        waited = 0;
        while (!drawing) begin
            waited++;
            if (waited > RISE_LIMIT) begin
                $display("timeout: drawing never started in frame %0d", frame);
                stop_with_failure();
            end
            wait_drive_point();
            wait_sample_point();
        end
        expect_equal($sformatf("frame %0d cycles before drawing", frame), waited, 0);

        count      = 0;
        screen_sum = '0;
        sprite_sum = '0;
        while (drawing) begin
            screen_sum += 32'(screen_addr);
            sprite_sum += 32'(sprite_addr);
            // ball is the last 1024 pixels
            if (count == gold_count - SPRITE_WORDS) begin
                expect_equal($sformatf("frame %0d ball start address", frame),
                             32'(screen_addr), gold_ball_addr);
            end
            count++;
            if (count > FRAME_LIMIT) begin
                $display("timeout: drawing never ended in frame %0d", frame);
                stop_with_failure();
            end
            wait_drive_point();
            // stray frame end in the middle of drawing
            pix_stb    = (count == INJECT_CYCLE);
            screen_end = (count == INJECT_CYCLE);
            wait_sample_point();
        end

        expect_equal($sformatf("frame %0d drawing cycles", frame), count, gold_count);
        expect_equal($sformatf("frame %0d screen address sum", frame),
                     screen_sum, gold_screen_sum);
        expect_equal($sformatf("frame %0d sprite address sum", frame),
                     sprite_sum, gold_sprite_sum);
        check_idle_outputs($sformatf("frame %0d after drawing", frame));
    endtask

    initial begin
        int    fd;
        int    fields;
        int    frames;
        int    cycles;
        string line;

        void'($urandom(5));
        pix_stb    = 1'b0;
        screen_end = 1'b0;
        start_menu = 1'b0;
        bl_x       = '0;
        bl_y       = '0;
        wh_x       = '0;
        wh_y       = '0;
        fh_pos_x   = '0;
        fh_pos_y   = '0;
        frames     = 0;

        cycles = 0;
        // state is only defined once the first edge has seen reset
        @(posedge CLK);
        wait_sample_point();
        while (rst) begin
            check_idle_outputs("reset");
            cycles++;
            if (cycles > RESET_LIMIT) begin
                $display("timeout: reset was never released");
                stop_with_failure();
            end
            wait_sample_point();
        end

        fd = $fopen("tests/layer_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/layer_golden.txt");
            stop_with_failure();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d",
                gold_menu, gold_bl_x, gold_bl_y, gold_wh_x, gold_wh_y,
                gold_fh_x[0], gold_fh_x[1], gold_fh_x[2], gold_fh_x[3],
                gold_fh_x[4], gold_fh_x[5], gold_fh_x[6],
                gold_fh_y[0], gold_fh_y[1], gold_fh_y[2], gold_fh_y[3],
                gold_fh_y[4], gold_fh_y[5], gold_fh_y[6],
                gold_count, gold_screen_sum, gold_sprite_sum, gold_ball_addr);
            if (fields != GOLD_FIELDS) begin
                $display("golden file line has %0d fields instead of %0d", fields, GOLD_FIELDS);
                stop_with_failure();
            end
            run_frame(frames);
            frames++;
        end
        $fclose(fd);

        if (frames == 0) begin
            $display("golden file holds no frames");
            stop_with_failure();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic CLK,
    output logic rst
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // release a little after the edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        rst = 1'b0;
    end

endmodule

// ==== src/layer_control.sv ====
`timescale 1ns/1ps

module layer_control
    import layer_pkg::*;
(
    input  logic         CLK,
    input  logic         rst,
    input  logic         i_pix_stb,
    input  logic         i_screen_end,
    input  logic         i_start_menu,
    input  coord_t       i_bl_x,
    input  coord_t       i_bl_y,
    input  coord_t       i_wh_x,
    input  coord_t       i_wh_y,
    input  fh_pos_bus_t  i_fh_pos_x,
    input  fh_pos_bus_t  i_fh_pos_y,
    output vram_addr_t   o_screen_addr,
    output sprite_addr_t o_sprite_addr,
    output logic         o_drawing
);

    logic         frame_start;
    logic         bg_enable;
    logic         fh_enable;
    logic         wh_enable;
    logic         bl_enable;
    logic         bg_done;
    logic         fh_sprite_done;
    logic         fh_layer_done;
    logic         wh_done;
    logic         bl_done;
    logic         fh_restart;
    coord_t       fh_pos_x;
    coord_t       fh_pos_y;
    vram_addr_t   bg_screen_addr;
    vram_addr_t   fh_screen_addr;
    vram_addr_t   wh_screen_addr;
    vram_addr_t   bl_screen_addr;
    sprite_addr_t bg_sprite_addr;
    sprite_addr_t fh_sprite_addr;
    sprite_addr_t wh_sprite_addr;
    sprite_addr_t bl_sprite_addr;

    // full screen, tiled from the background slot
    sprite_walker #(
        .WIDTH       (SCREEN_WIDTH),
        .HEIGHT      (SCREEN_HEIGHT),
        .SPRITE_INDEX(SPRITE_BG_INDEX)
    ) u_bg_walker (
        .CLK          (CLK),
        .rst          (rst),
        .i_restart    (frame_start),
        .i_enable     (bg_enable),
        .i_pos_x      (coord_t'(0)),
        .i_pos_y      (coord_t'(0)),
        .o_screen_addr(bg_screen_addr),
        .o_sprite_addr(bg_sprite_addr),
        .o_done       (bg_done)
    );

    // one walker reused for every fail hole
    sprite_walker #(
        .SPRITE_INDEX(SPRITE_FH_INDEX)
    ) u_fh_walker (
        .CLK          (CLK),
        .rst          (rst),
        .i_restart    (fh_restart),
        .i_enable     (fh_enable),
        .i_pos_x      (fh_pos_x),
        .i_pos_y      (fh_pos_y),
        .o_screen_addr(fh_screen_addr),
        .o_sprite_addr(fh_sprite_addr),
        .o_done       (fh_sprite_done)
    );

    failhole_sequencer u_fh_seq (
        .CLK          (CLK),
        .rst          (rst),
        .i_frame_start(frame_start),
        .i_sprite_done(fh_sprite_done),
        .i_fh_pos_x   (i_fh_pos_x),
        .i_fh_pos_y   (i_fh_pos_y),
        .o_restart    (fh_restart),
        .o_pos_x      (fh_pos_x),
        .o_pos_y      (fh_pos_y),
        .o_layer_done (fh_layer_done)
    );

    sprite_walker #(
        .SPRITE_INDEX(SPRITE_WH_INDEX)
    ) u_wh_walker (
        .CLK          (CLK),
        .rst          (rst),
        .i_restart    (frame_start),
        .i_enable     (wh_enable),
        .i_pos_x      (i_wh_x),
        .i_pos_y      (i_wh_y),
        .o_screen_addr(wh_screen_addr),
        .o_sprite_addr(wh_sprite_addr),
        .o_done       (wh_done)
    );

    sprite_walker #(
        .SPRITE_INDEX(SPRITE_BL_INDEX)
    ) u_bl_walker (
        .CLK          (CLK),
        .rst          (rst),
        .i_restart    (frame_start),
        .i_enable     (bl_enable),
        .i_pos_x      (i_bl_x),
        .i_pos_y      (i_bl_y),
        .o_screen_addr(bl_screen_addr),
        .o_sprite_addr(bl_sprite_addr),
        .o_done       (bl_done)
    );

    layer_sequencer u_layer_seq (
        .CLK             (CLK),
        .rst             (rst),
        .i_pix_stb       (i_pix_stb),
        .i_screen_end    (i_screen_end),
        .i_start_menu    (i_start_menu),
        .i_bg_done       (bg_done),
        .i_fh_done       (fh_layer_done),
        .i_wh_done       (wh_done),
        .i_bl_done       (bl_done),
        .i_bg_screen_addr(bg_screen_addr),
        .i_bg_sprite_addr(bg_sprite_addr),
        .i_fh_screen_addr(fh_screen_addr),
        .i_fh_sprite_addr(fh_sprite_addr),
        .i_wh_screen_addr(wh_screen_addr),
        .i_wh_sprite_addr(wh_sprite_addr),
        .i_bl_screen_addr(bl_screen_addr),
        .i_bl_sprite_addr(bl_sprite_addr),
        .o_frame_start   (frame_start),
        .o_bg_enable     (bg_enable),
        .o_fh_enable     (fh_enable),
        .o_wh_enable     (wh_enable),
        .o_bl_enable     (bl_enable),
        .o_screen_addr   (o_screen_addr),
        .o_sprite_addr   (o_sprite_addr),
        .o_drawing       (o_drawing)
    );

endmodule

// ==== src/layer_sequencer.sv ====
`timescale 1ns/1ps

module layer_sequencer
    import layer_pkg::*;
(
    input  logic         CLK,
    input  logic         rst,
    input  logic         i_pix_stb,
    input  logic         i_screen_end,
    input  logic         i_start_menu,
    input  logic         i_bg_done,
    input  logic         i_fh_done,
    input  logic         i_wh_done,
    input  logic         i_bl_done,
    input  vram_addr_t   i_bg_screen_addr,
    input  sprite_addr_t i_bg_sprite_addr,
    input  vram_addr_t   i_fh_screen_addr,
    input  sprite_addr_t i_fh_sprite_addr,
    input  vram_addr_t   i_wh_screen_addr,
    input  sprite_addr_t i_wh_sprite_addr,
    input  vram_addr_t   i_bl_screen_addr,
    input  sprite_addr_t i_bl_sprite_addr,
    output logic         o_frame_start,
    output logic         o_bg_enable,
    output logic         o_fh_enable,
    output logic         o_wh_enable,
    output logic         o_bl_enable,
    output vram_addr_t   o_screen_addr,
    output sprite_addr_t o_sprite_addr,
    output logic         o_drawing
);

    layer_state_t state;
    layer_state_t state_next;
    logic         new_frame;

    assign new_frame     = i_pix_stb && i_screen_end;
    // frame end while drawing is dropped
    assign o_frame_start = (state == LAYER_IDLE) && new_frame;

    always_comb begin
        state_next = state;
        case (state)
            LAYER_IDLE: begin
                if (new_frame) begin
                    state_next = LAYER_BACKGROUND;
                end
            end
            LAYER_BACKGROUND: begin
                if (i_bg_done) begin
                    // start menu has no holes
                    state_next = i_start_menu ? LAYER_BALL : LAYER_FAILHOLE;
                end
            end
            LAYER_FAILHOLE: begin
                if (i_fh_done) begin
                    state_next = LAYER_WINHOLE;
                end
            end
            LAYER_WINHOLE: begin
                if (i_wh_done) begin
                    state_next = LAYER_BALL;
                end
            end
            LAYER_BALL: begin
                if (i_bl_done) begin
                    state_next = LAYER_IDLE;
                end
            end
            default: begin
                state_next = LAYER_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= LAYER_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign o_bg_enable = (state == LAYER_BACKGROUND);
    assign o_fh_enable = (state == LAYER_FAILHOLE);
    assign o_wh_enable = (state == LAYER_WINHOLE);
    assign o_bl_enable = (state == LAYER_BALL);
    assign o_drawing   = (state != LAYER_IDLE);

    // address mux drives zero while idle
    always_comb begin
        case (state)
            LAYER_BACKGROUND: begin
                o_screen_addr = i_bg_screen_addr;
                o_sprite_addr = i_bg_sprite_addr;
            end
            LAYER_FAILHOLE: begin
                o_screen_addr = i_fh_screen_addr;
                o_sprite_addr = i_fh_sprite_addr;
            end
            LAYER_WINHOLE: begin
                o_screen_addr = i_wh_screen_addr;
                o_sprite_addr = i_wh_sprite_addr;
            end
            LAYER_BALL: begin
                o_screen_addr = i_bl_screen_addr;
                o_sprite_addr = i_bl_sprite_addr;
            end
            default: begin
                o_screen_addr = '0;
                o_sprite_addr = '0;
            end
        endcase
    end

endmodule

// ==== src/failhole_sequencer.sv ====
`timescale 1ns/1ps

module failhole_sequencer
    import layer_pkg::*;
(
    input  logic        CLK,
    input  logic        rst,
    input  logic        i_frame_start,
    input  logic        i_sprite_done,
    input  fh_pos_bus_t i_fh_pos_x,
    input  fh_pos_bus_t i_fh_pos_y,
    output logic        o_restart,
    output coord_t      o_pos_x,
    output coord_t      o_pos_y,
    output logic        o_layer_done
);

    logic [FH_CNT_BITS-1:0] fh_cnt;
    logic                   last_hole;
    logic                   next_hole;

    assign last_hole = (fh_cnt == FH_CNT_BITS'(FAILHOLE_COUNT - 1));
    assign next_hole = i_sprite_done && !last_hole;

    // walker restarts on a new frame and between holes
    assign o_restart    = i_frame_start || next_hole;
    assign o_layer_done = i_sprite_done && last_hole;

    always_ff @(posedge CLK) begin
        if (rst) begin
            fh_cnt <= '0;
        end else if (i_frame_start) begin
            fh_cnt <= '0;
        end else if (next_hole) begin
            fh_cnt <= fh_cnt + FH_CNT_BITS'(1);
        end
    end

    // current hole's slot out of the packed buses
    assign o_pos_x = i_fh_pos_x[fh_cnt * COORD_BITS +: COORD_BITS];
    assign o_pos_y = i_fh_pos_y[fh_cnt * COORD_BITS +: COORD_BITS];

endmodule

// ==== src/sprite_walker.sv ====
`timescale 1ns/1ps

module sprite_walker
    import layer_pkg::*;
#(
    parameter int WIDTH        = SPRITE_SIZE,
    parameter int HEIGHT       = SPRITE_SIZE,
    parameter int SPRITE_INDEX = 0
) (
    input  logic         CLK,
    input  logic         rst,
    input  logic         i_restart,
    input  logic         i_enable,
    input  coord_t       i_pos_x,
    input  coord_t       i_pos_y,
    output vram_addr_t   o_screen_addr,
    output sprite_addr_t o_sprite_addr,
    output logic         o_done
);

    coord_t       x_cnt;
    coord_t       y_cnt;
    logic         finished;
    logic         last_col;
    logic         last_pix;
    vram_addr_t   row;
    vram_addr_t   col;
    sprite_addr_t sprite_base;
    sprite_addr_t sprite_offset;

    assign last_col = (x_cnt == coord_t'(WIDTH - 1));
    assign last_pix = last_col && (y_cnt == coord_t'(HEIGHT - 1));
    assign o_done   = i_enable && !finished && last_pix;

    // steps x before y and holds the last pixel until restarted
    always_ff @(posedge CLK) begin
        if (rst) begin
            x_cnt    <= '0;
            y_cnt    <= '0;
            finished <= 1'b1;
        end else if (i_restart) begin
            x_cnt    <= '0;
            y_cnt    <= '0;
            finished <= 1'b0;
        end else if (i_enable && !finished) begin
            if (last_pix) begin
                finished <= 1'b1;
            end else if (last_col) begin
                x_cnt <= '0;
                y_cnt <= y_cnt + coord_t'(1);
            end else begin
                x_cnt <= x_cnt + coord_t'(1);
            end
        end
    end

    assign row           = vram_addr_t'(i_pos_y) + vram_addr_t'(y_cnt);
    assign col           = vram_addr_t'(i_pos_x) + vram_addr_t'(x_cnt);
    assign o_screen_addr = row * vram_addr_t'(SCREEN_WIDTH) + col;

    // low counter bits give the mod that tiles the background
    assign sprite_base   = sprite_addr_t'(SPRITE_INDEX * SPRITE_WORDS);
    assign sprite_offset = sprite_addr_t'({y_cnt[SPRITE_BITS-1:0], x_cnt[SPRITE_BITS-1:0]});
    assign o_sprite_addr = sprite_base + sprite_offset;

endmodule

// ==== src/layer_pkg.sv ====
package layer_pkg;

    // screen geometry in pixels
    localparam int SCREEN_WIDTH  = 320;
    localparam int SCREEN_HEIGHT = 180;

    // square sprites with a power-of-two side
    localparam int SPRITE_SIZE  = 32;
    localparam int SPRITE_BITS  = $clog2(SPRITE_SIZE);
    localparam int SPRITE_WORDS = SPRITE_SIZE * SPRITE_SIZE;

    localparam int COORD_BITS     = 10;
    localparam int FAILHOLE_COUNT = 7;
    localparam int FH_CNT_BITS    = $clog2(FAILHOLE_COUNT);

    // sprite buffer slots
    localparam int SPRITE_BG_INDEX = 0;
    localparam int SPRITE_BL_INDEX = 1;
    localparam int SPRITE_FH_INDEX = 2;
    localparam int SPRITE_WH_INDEX = 3;

    typedef logic [COORD_BITS-1:0] coord_t;
    typedef logic [15:0]           vram_addr_t;
    typedef logic [14:0]           sprite_addr_t;

    // hole 0 sits in the lowest coordinate slot
    typedef logic [FAILHOLE_COUNT*COORD_BITS-1:0] fh_pos_bus_t;

    typedef enum logic [2:0] {
        LAYER_IDLE,
        LAYER_BACKGROUND,
        LAYER_FAILHOLE,
        LAYER_WINHOLE,
        LAYER_BALL
    } layer_state_t;

endpackage
